//--- hdl/bank_collect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response collector, merges bank read data into one stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bank_collect (
   input  mem_pkg::bank_rsp_t rsp_in [mem_pkg::N_BANKS],
   output mem_pkg::bank_rsp_t rsp
);

   logic [mem_pkg::N_BANKS-1:0] vld;

   // OR of the one-hot responses, word is the bank number
   always_comb begin
      rsp = '0;
      for (int i = 0; i < mem_pkg::N_BANKS; i++) begin
         vld[i] = rsp_in[i].valid;
         if (rsp_in[i].valid) begin
            rsp.valid = 1'b1;
            rsp.word  = rsp.word | rsp_in[i].word;
            rsp.rdata = rsp.rdata | rsp_in[i].rdata;
         end
      end
   end

   // Staggered reads keep bank returns apart
   always_comb begin
      assert final ($onehot0(vld));
   end

endmodule

//--- hdl/bank_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank dispatcher, steers each request to its bank port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bank_dispatch (
   input  logic                        clk,
   input  logic                        rst_n,
   input  mem_pkg::bank_req_t          req,
   input  logic [mem_pkg::N_BANKS-1:0] busy,
   output mem_pkg::bank_req_t          bank_req [mem_pkg::N_BANKS]
);

   always_comb begin
      for (int b = 0; b < mem_pkg::N_BANKS; b++) begin
         // Address and data broadcast, strobes to one bank only
         bank_req[b] = req;
         if (req.addr.bank_view.bank != 2'(b)) begin
            bank_req[b].rd = 1'b0;
            bank_req[b].wr = 1'b0;
         end
      end
   end

   // Controller sequencing must keep clear of busy banks
   assert property (@(posedge clk) disable iff (!rst_n)
      (req.rd || req.wr) |-> !busy[req.addr.bank_view.bank]);

endmodule

//--- hdl/cache_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache controller FSM
// Hit check, victim writeback, pipelined line fill, final access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_ctrl (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_pkg::addr_u     addr,
   input  mem_pkg::word_t     data_in,
   input  logic               rd,
   input  logic               wr,
   output mem_pkg::word_t     data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err,
   output logic               c_en,
   output logic               c_comp,
   output logic               c_write,
   output mem_pkg::tag_t      c_tag,
   output mem_pkg::index_t    c_index,
   output logic [1:0]         c_word,
   output mem_pkg::word_t     c_wdata,
   input  logic               c_hit,
   input  logic               c_valid,
   input  logic               c_dirty,
   input  mem_pkg::tag_t      c_tag_out,
   input  mem_pkg::word_t     c_rdata,
   output mem_pkg::bank_req_t req,
   input  mem_pkg::bank_rsp_t rsp
);

   localparam logic [2:0] S_IDLE  = 3'd0;
   localparam logic [2:0] S_COMP  = 3'd1;
   localparam logic [2:0] S_CHECK = 3'd2;
   localparam logic [2:0] S_ERR   = 3'd3;
   localparam logic [2:0] S_WB    = 3'd4;
   localparam logic [2:0] S_FILL  = 3'd5;
   localparam logic [2:0] S_WAIT  = 3'd6;

   logic [2:0]      state;
   logic [2:0]      state_nxt;
   logic [2:0]      cnt;
   logic [2:0]      cnt_nxt;
   logic [2:0]      pending;
   logic            miss_q;
   mem_pkg::addr_u  addr_q;
   mem_pkg::word_t  data_q;
   logic            wr_q;

   always_comb begin
      state_nxt = state;
      cnt_nxt   = cnt;
      // Cache defaults to the registered request
      c_en      = 1'b0;
      c_comp    = 1'b0;
      c_write   = 1'b0;
      c_tag     = addr_q.cache_view.tag;
      c_index   = addr_q.cache_view.index;
      c_word    = addr_q.cache_view.word;
      c_wdata   = data_q;
      req.addr  = addr_q;
      req.wdata = c_rdata;
      req.rd    = 1'b0;
      req.wr    = 1'b0;
      case (state)
         S_IDLE: begin
            if (rd || wr) begin
               // Odd address or both strobes, finish with err
               if (addr.cache_view.byte_bit || (rd && wr)) begin
                  state_nxt = S_ERR;
               end else begin
                  state_nxt = S_COMP;
               end
            end
         end
         S_COMP: begin
            c_en      = 1'b1;
            c_comp    = 1'b1;
            c_write   = wr_q;
            state_nxt = S_CHECK;
         end
         S_CHECK: begin
            cnt_nxt = '0;
            if (c_hit) begin
               state_nxt = S_IDLE;
            end else if (c_valid && c_dirty) begin
               state_nxt = S_WB;
            end else begin
               state_nxt = S_FILL;
            end
         end
         S_ERR: begin
            state_nxt = S_IDLE;
         end
         S_WB: begin
            // Cache read of word cnt
            if (cnt != 3'd4) begin
               c_en   = 1'b1;
               c_word = cnt[1:0];
            end
            // Bank write of word cnt-1, one cycle behind the read
            if (cnt != 3'd0) begin
               req.wr                   = 1'b1;
               req.addr.cache_view.tag  = c_tag_out;
               req.addr.cache_view.word = cnt[1:0] - 2'd1;
            end
            cnt_nxt = cnt + 3'd1;
            if (cnt == 3'd4) begin
               cnt_nxt   = '0;
               state_nxt = S_FILL;
            end
         end
         S_FILL: begin
            // Word k goes to bank k, one read per cycle
            req.rd                   = 1'b1;
            req.addr.cache_view.word = cnt[1:0];
            cnt_nxt                  = cnt + 3'd1;
            if (cnt == 3'd3) begin
               state_nxt = S_WAIT;
            end
         end
         S_WAIT: begin
            // Last outstanding word lands this cycle
            if (rsp.valid && (pending == 3'd1)) begin
               state_nxt = S_COMP;
            end
         end
         default: begin
            state_nxt = S_IDLE;
         end
      endcase
      // Fill data written into the line as it arrives
      if (rsp.valid) begin
         c_en    = 1'b1;
         c_comp  = 1'b0;
         c_write = 1'b1;
         c_word  = rsp.word;
         c_wdata = rsp.rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= S_IDLE;
         cnt     <= '0;
         pending <= '0;
         miss_q  <= 1'b0;
      end else begin
         state   <= state_nxt;
         cnt     <= cnt_nxt;
         // Reads in flight across the banks
         pending <= pending + {2'b00, req.rd} - {2'b00, rsp.valid};
         if (state == S_IDLE) begin
            miss_q <= 1'b0;
         end else if ((state == S_CHECK) && !c_hit) begin
            miss_q <= 1'b1;
         end
      end
   end

   // Request captured at acceptance
   always_ff @(posedge clk) begin
      if ((state == S_IDLE) && (rd || wr)) begin
         addr_q <= addr;
         data_q <= data_in;
         wr_q   <= wr;
      end
   end

   assign done      = ((state == S_CHECK) && c_hit) || (state == S_ERR);
   // First compare decides the reported hit
   assign cache_hit = (state == S_CHECK) && c_hit && !miss_q;
   assign err       = (state == S_ERR);
   assign stall     = (state != S_IDLE) && (state != S_ERR) &&
                      !((state == S_CHECK) && c_hit);
   assign data_out  = c_rdata;

   assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);
   // Accesses other than errors stay stalled right up to done
   assert property (@(posedge clk) disable iff (!rst_n)
      (done && !err) |-> $past(stall));

endmodule

//--- hdl/cache_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped cache arrays, 256 lines of four words
// Compare mode and access mode, registered outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_store (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            en,
   input  logic            comp,
   input  logic            write,
   input  mem_pkg::tag_t   tag_in,
   input  mem_pkg::index_t index,
   input  logic [1:0]      word,
   input  mem_pkg::word_t  wdata,
   output logic            hit,
   output logic            valid,
   output logic            dirty,
   output mem_pkg::tag_t   tag_out,
   output mem_pkg::word_t  rdata
);

   mem_pkg::tag_t  tag_mem   [256];
   mem_pkg::word_t data_mem  [256][4];
   logic           dirty_mem [256];
   logic [255:0]   valid_bits;
   logic           line_hit;

   // Tag match on a valid line
   assign line_hit = valid_bits[index] && (tag_mem[index] == tag_in);

   // Only an access-mode write can validate a line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_bits <= '0;
      end else if (en && write && !comp) begin
         valid_bits[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (en && write) begin
         if (!comp) begin
            // Line fill, clean copy of memory
            data_mem[index][word] <= wdata;
            tag_mem[index]        <= tag_in;
            dirty_mem[index]      <= 1'b0;
         end else if (line_hit) begin
            // Store hit, line now differs from memory
            data_mem[index][word] <= wdata;
            dirty_mem[index]      <= 1'b1;
         end
      end
   end

   // Status seen by the controller one cycle later
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hit   <= 1'b0;
         valid <= 1'b0;
         dirty <= 1'b0;
      end else if (en) begin
         hit   <= line_hit;
         valid <= valid_bits[index];
         dirty <= dirty_mem[index];
      end
   end

   // Old word and tag, victim data during writeback
   always_ff @(posedge clk) begin
      if (en) begin
         tag_out <= tag_mem[index];
         rdata   <= data_mem[index][word];
      end
   end

   // A write strobe without enable would be lost
   assert property (@(posedge clk) disable iff (!rst_n) write |-> en);

endmodule

//--- hdl/mem_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One 8K-word memory bank
// Immediate writes, reads through a BANK_LAT delay line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_bank #(
   parameter int BANK_LAT = 2
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_pkg::bank_req_t req,
   output logic               busy,
   output mem_pkg::bank_rsp_t rsp
);

   localparam int CW = $clog2(BANK_LAT + 1);

   mem_pkg::word_t      mem       [8192];
   logic [CW-1:0]       busy_cnt;
   logic [BANK_LAT-1:0] vld_pipe;
   mem_pkg::word_t      data_pipe [BANK_LAT];
   logic [1:0]          bank_pipe [BANK_LAT];

   always_ff @(posedge clk) begin
      if (req.wr) begin
         mem[req.addr.bank_view.row] <= req.wdata;
      end
   end

   // Occupied for BANK_LAT cycles counting the request cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_cnt <= '0;
      end else if (req.rd || req.wr) begin
         busy_cnt <= CW'(BANK_LAT - 1);
      end else if (busy_cnt != '0) begin
         busy_cnt <= busy_cnt - 1'b1;
      end
   end

   assign busy = (busy_cnt != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe[0] <= req.rd;
         for (int i = 1; i < BANK_LAT; i++) begin
            vld_pipe[i] <= vld_pipe[i-1];
         end
      end
   end

   // Read data and bank number ride alongside the valid
   always_ff @(posedge clk) begin
      data_pipe[0] <= mem[req.addr.bank_view.row];
      bank_pipe[0] <= req.addr.bank_view.bank;
      for (int i = 1; i < BANK_LAT; i++) begin
         data_pipe[i] <= data_pipe[i-1];
         bank_pipe[i] <= bank_pipe[i-1];
      end
   end

   assign rsp.valid = vld_pipe[BANK_LAT-1];
   assign rsp.word  = bank_pipe[BANK_LAT-1];
   assign rsp.rdata = data_pipe[BANK_LAT-1];

   assert property (@(posedge clk) disable iff (!rst_n) !(req.rd && req.wr));

endmodule

//--- hdl/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the cached four-bank memory system
// Word, tag and index types, address union, bank structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

   // Number of interleaved banks
   localparam int N_BANKS = 4;

   typedef logic [15:0] word_t;
   typedef logic [4:0]  tag_t;
   typedef logic [7:0]  index_t;

   // Cache decode of a byte address
   typedef struct packed {
      tag_t       tag;
      index_t     index;
      logic [1:0] word;
      logic       byte_bit;
   } cache_view_t;

   // Memory decode of the same address
   typedef struct packed {
      logic [12:0] row;
      logic [1:0]  bank;
      logic        byte_bit;
   } bank_view_t;

   // Word-in-line and bank number share bits [2:1]
   typedef union packed {
      cache_view_t cache_view;
      bank_view_t  bank_view;
   } addr_u;

   // Controller to banks
   typedef struct packed {
      addr_u addr;
      word_t wdata;
      logic  rd;
      logic  wr;
   } bank_req_t;

   // Banks to controller, word is the line position
   typedef struct packed {
      logic       valid;
      logic [1:0] word;
      word_t      rdata;
   } bank_rsp_t;

endpackage

//--- hdl/mem_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory system top level
// Controller, cache arrays, dispatcher, four banks, collector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_system #(
   parameter int BANK_LAT = 2
) (
   input  logic           clk,
   input  logic           rst_n,
   input  mem_pkg::addr_u addr,
   input  mem_pkg::word_t data_in,
   input  logic           rd,
   input  logic           wr,
   output mem_pkg::word_t data_out,
   output logic           done,
   output logic           stall,
   output logic           cache_hit,
   output logic           err
);

   // Controller to cache arrays
   logic            c_en;
   logic            c_comp;
   logic            c_write;
   mem_pkg::tag_t   c_tag;
   mem_pkg::index_t c_index;
   logic [1:0]      c_word;
   mem_pkg::word_t  c_wdata;
   logic            c_hit;
   logic            c_valid;
   logic            c_dirty;
   mem_pkg::tag_t   c_tag_out;
   mem_pkg::word_t  c_rdata;

   // Memory side
   mem_pkg::bank_req_t          req;
   mem_pkg::bank_rsp_t          rsp;
   mem_pkg::bank_req_t          bank_req [mem_pkg::N_BANKS];
   mem_pkg::bank_rsp_t          bank_rsp [mem_pkg::N_BANKS];
   logic [mem_pkg::N_BANKS-1:0] busy;

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .c_en      (c_en),
      .c_comp    (c_comp),
      .c_write   (c_write),
      .c_tag     (c_tag),
      .c_index   (c_index),
      .c_word    (c_word),
      .c_wdata   (c_wdata),
      .c_hit     (c_hit),
      .c_valid   (c_valid),
      .c_dirty   (c_dirty),
      .c_tag_out (c_tag_out),
      .c_rdata   (c_rdata),
      .req       (req),
      .rsp       (rsp)
   );

   cache_store u_store (
      .clk     (clk),
      .rst_n   (rst_n),
      .en      (c_en),
      .comp    (c_comp),
      .write   (c_write),
      .tag_in  (c_tag),
      .index   (c_index),
      .word    (c_word),
      .wdata   (c_wdata),
      .hit     (c_hit),
      .valid   (c_valid),
      .dirty   (c_dirty),
      .tag_out (c_tag_out),
      .rdata   (c_rdata)
   );

   bank_dispatch u_dispatch (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .busy     (busy),
      .bank_req (bank_req)
   );

   // Word k of every line lives in bank k
   for (genvar b = 0; b < mem_pkg::N_BANKS; b++) begin : g_bank
      mem_bank #(
         .BANK_LAT (BANK_LAT)
      ) u_bank (
         .clk   (clk),
         .rst_n (rst_n),
         .req   (bank_req[b]),
         .busy  (busy[b]),
         .rsp   (bank_rsp[b])
      );
   end

   bank_collect u_collect (
      .rsp_in (bank_rsp),
      .rsp    (rsp)
   );

endmodule

//--- mem_system.f
hdl/mem_pkg.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/bank_dispatch.sv
hdl/mem_bank.sv
hdl/bank_collect.sv
hdl/mem_system.sv
test/tb_mem_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
   -f mem_system.f --top-module tb_mem_system
./obj_dir/Vtb_mem_system | tee sim.log

# Pass only if the testbench printed its pass line
if grep -q "^NO ERRORS$" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

//--- test/tb_mem_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the cached four-bank memory system
// LFSR, reference cache and memory model, compare tasks,
// directed and random tests, cycle-count timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mem_system;

   // 200 requests, a miss costs at most about 25 cycles, plus margin
   localparam int N_REQ_MAX   = 200;
   localparam int MISS_CYC    = 25;
   localparam int CYCLE_LIMIT = N_REQ_MAX * MISS_CYC + 1000;

   logic           clk;
   logic           rst_n;
   mem_pkg::addr_u addr;
   mem_pkg::word_t data_in;
   logic           rd;
   logic           wr;
   mem_pkg::word_t data_out;
   logic           done;
   logic           stall;
   logic           cache_hit;
   logic           err;

   // Reference model state
   mem_pkg::tag_t  ref_tag   [256];
   logic           ref_valid [256];
   logic           ref_dirty [256];
   mem_pkg::word_t ref_mem   [int];
   int             wb_count;

   // Expectation of the request in flight
   logic           exp_open;
   logic           exp_err;
   logic           exp_hit;
   logic           exp_rd;
   mem_pkg::word_t exp_data;

   logic [19:0]    lfsr;
   int             n_err;
   int             n_checks;
   int             n_tests;
   int             n_req;
   int             base_err;
   int             cycle_cnt;
   string          cur_test;

   mem_system #(
      .BANK_LAT (2)
   ) dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #5 clk = ~clk;

   // x^20 + x^17 + 1, one step per bit taken
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[18:0], lfsr[19] ^ lfsr[16]};
         r    = {r[14:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic mem_pkg::addr_u make_addr(input mem_pkg::tag_t t,
                                                input mem_pkg::index_t i,
                                                input logic [1:0] w);
      mem_pkg::addr_u a;
      a.cache_view.tag      = t;
      a.cache_view.index    = i;
      a.cache_view.word     = w;
      a.cache_view.byte_bit = 1'b0;
      return a;
   endfunction

   // Direct-mapped lookup, returns the expected hit and updates the model
   function automatic logic model_access(input mem_pkg::addr_u a, input logic is_wr,
                                         input mem_pkg::word_t wd);
      mem_pkg::index_t idx;
      logic            hit;
      idx = a.cache_view.index;
      hit = ref_valid[idx] && (ref_tag[idx] == a.cache_view.tag);
      if (!hit) begin
         // Dirty victim goes back to memory first
         if (ref_valid[idx] && ref_dirty[idx]) begin
            wb_count++;
         end
         ref_valid[idx] = 1'b1;
         ref_tag[idx]   = a.cache_view.tag;
         ref_dirty[idx] = 1'b0;
      end
      if (is_wr) begin
         ref_mem[int'(a[15:1])] = wd;
         ref_dirty[idx]         = 1'b1;
      end
      return hit;
   endfunction

   // Last word written at a word address
   function automatic mem_pkg::word_t expected_word(input mem_pkg::addr_u a);
      return ref_mem[int'(a[15:1])];
   endfunction

   task automatic check_word(input string name, input mem_pkg::word_t exp,
                             input mem_pkg::word_t act);
      n_checks++;
      if (act !== exp) begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
         n_err++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
         n_err++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      base_err = n_err;
      n_tests++;
   endtask

   task automatic end_test();
      if (n_err == base_err) begin
         $display("test %s: passed", cur_test);
      end else begin
         $display("test %s: failed with %0d errors", cur_test, n_err - base_err);
      end
   endtask

   // One request, held for a cycle, then wait for done
   task automatic run_req(input mem_pkg::addr_u a, input logic do_rd, input logic do_wr,
                          input mem_pkg::word_t wd);
      int lat;
      @(posedge clk);
      #1;
      exp_err = a.cache_view.byte_bit || (do_rd && do_wr);
      exp_hit = 1'b0;
      exp_rd  = 1'b0;
      if (!exp_err) begin
         exp_hit = model_access(a, do_wr, wd);
         exp_rd  = do_rd;
         if (do_rd) begin
            exp_data = expected_word(a);
         end
      end
      exp_open = 1'b1;
      addr     = a;
      data_in  = wd;
      rd       = do_rd;
      wr       = do_wr;
      @(posedge clk);
      #1;
      rd  = 1'b0;
      wr  = 1'b0;
      lat = 1;
      @(negedge clk);
      while (!done) begin
         // Held off from acceptance until done
         check_flag("stall", 1'b1, stall);
         @(negedge clk);
         lat++;
      end
      // Fixed latencies of errors and hits
      if (exp_err && (lat != 1)) begin
         $display("error request at %0t took %0d cycles instead of 1", $time, lat);
         n_err++;
      end else if (!exp_err && exp_hit && (lat != 2)) begin
         $display("hit at %0t took %0d cycles instead of 2", $time, lat);
         n_err++;
      end
      n_req++;
   endtask

   // Compares every done against the expectation
   always @(negedge clk) begin
      if (rst_n && done) begin
         if (!exp_open) begin
            $display("done pulsed at %0t with no request outstanding", $time);
            n_err++;
         end else begin
            check_flag("err", exp_err, err);
            check_flag("cache_hit", exp_hit, cache_hit);
            check_flag("stall", 1'b0, stall);
            if (exp_rd) begin
               check_word("data_out", exp_data, data_out);
            end
         end
         exp_open = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      mem_pkg::addr_u a;
      mem_pkg::addr_u b;
      mem_pkg::addr_u written [$];
      int             pick;
      clk       = 1'b0;
      rst_n     = 1'b0;
      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      lfsr      = 20'd98674;
      exp_open  = 1'b0;
      exp_err   = 1'b0;
      exp_hit   = 1'b0;
      exp_rd    = 1'b0;
      exp_data  = '0;
      n_err     = 0;
      n_checks  = 0;
      n_tests   = 0;
      n_req     = 0;
      wb_count  = 0;
      cycle_cnt = 0;
      for (int i = 0; i < 256; i++) begin
         ref_valid[i] = 1'b0;
         ref_dirty[i] = 1'b0;
         ref_tag[i]   = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Idle levels, then a cold write
      begin_test("reset state");
      @(negedge clk);
      check_flag("stall", 1'b0, stall);
      check_flag("done", 1'b0, done);
      check_flag("cache_hit", 1'b0, cache_hit);
      check_flag("err", 1'b0, err);
      run_req(make_addr(5'd7, 8'h10, 2'd3), 1'b0, 1'b1, 16'h1357);
      end_test();

      begin_test("write then read");
      a = make_addr(5'd1, 8'h20, 2'd1);
      run_req(a, 1'b0, 1'b1, 16'hbeef);
      run_req(a, 1'b1, 1'b0, '0);
      end_test();

      // Fill one line, evict it dirty, bring it back
      begin_test("line fill");
      for (int w = 0; w < 4; w++) begin
         run_req(make_addr(5'd4, 8'h30, 2'(w)), 1'b0, 1'b1, 16'h3000 + 16'(w));
      end
      run_req(make_addr(5'd5, 8'h30, 2'd0), 1'b0, 1'b1, 16'h5a5a);
      for (int w = 0; w < 4; w++) begin
         run_req(make_addr(5'd4, 8'h30, 2'(w)), 1'b1, 1'b0, '0);
      end
      end_test();

      begin_test("dirty writeback");
      a = make_addr(5'd2, 8'h40, 2'd2);
      b = make_addr(5'd3, 8'h40, 2'd2);
      run_req(a, 1'b0, 1'b1, 16'haaaa);
      run_req(b, 1'b0, 1'b1, 16'hbbbb);
      run_req(a, 1'b1, 1'b0, '0);
      run_req(b, 1'b1, 1'b0, '0);
      end_test();

      // Odd address and both strobes leave the line alone
      begin_test("error requests");
      a = make_addr(5'd1, 8'h20, 2'd1);
      b = a;
      b.cache_view.byte_bit = 1'b1;
      run_req(b, 1'b1, 1'b0, '0);
      run_req(b, 1'b0, 1'b1, 16'h0bad);
      run_req(a, 1'b1, 1'b1, 16'hdead);
      run_req(a, 1'b1, 1'b0, '0);
      end_test();

      // Small tag and index set keeps conflicts frequent
      begin_test("random mix");
      for (int i = 0; i < 150; i++) begin
         if ((written.size() == 0) || (rand_bits(1) == 16'd1)) begin
            a = make_addr(5'(rand_bits(2)), 8'h80 + 8'(rand_bits(2)), 2'(rand_bits(2)));
            run_req(a, 1'b0, 1'b1, rand_bits(16));
            written.push_back(a);
         end else begin
            pick = int'(rand_bits(8)) % written.size();
            run_req(written[pick], 1'b1, 1'b0, '0);
         end
      end
      end_test();

      $display("%0d tests, %0d requests, %0d checks, %0d errors, %0d model writebacks",
               n_tests, n_req, n_checks, n_err, wb_count);
      if (n_err == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
